/* verilog/ex_pkg.sv */
/*
 * execute stage shared types
 * alu operation and branch comparison codes, numbered for vector files
 */
`default_nettype none

package ex_pkg;

    // alu operation select, codes fixed for stimulus files
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,   // a + b
        ALU_SUB   = 4'd1,   // a - b
        ALU_SLL   = 4'd2,   // logical left shift
        ALU_SLT   = 4'd3,   // signed less than
        ALU_SLTU  = 4'd4,   // unsigned less than
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,   // logical right shift
        ALU_SRA   = 4'd7,   // arithmetic right shift
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10   // operand b through, lui
    } alu_op_e;

    // branch compare type, follows the funct3 field of the branch opcode
    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,   // beq
        BR_NE  = 3'd1,   // bne
        BR_LT  = 3'd4,   // blt, signed
        BR_GE  = 3'd5,   // bge, signed
        BR_LTU = 3'd6,   // bltu
        BR_GEU = 3'd7    // bgeu
    } br_type_e;

endpackage

`default_nettype wire

/* verilog/alu.sv */
/*
 * integer alu for the execute stage
 * purely combinational, one operation per cycle selected by op
 */
`timescale 1ns/1ps
`default_nettype none

module alu
    import ex_pkg::*;
#(
    parameter int xlen = 64
) (
    input  alu_op_e           op,      // operation select
    input  logic [xlen-1:0]   a,       // operand a, pc or rs1
    input  logic [xlen-1:0]   b,       // operand b, rs2 or imm
    output logic [xlen-1:0]   result
);

    localparam int shamt_w = $clog2(xlen);   // 6 bits at 64, 5 at 32

    logic [shamt_w-1:0] shamt;     // shift amount from low bits of b
    logic               lt_s;      // signed compare
    logic               lt_u;      // unsigned compare

    assign shamt = b[shamt_w-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);   // sign fill from msb
            end
            ALU_SLT: begin
                result = {{(xlen-1){1'b0}}, lt_s};   // 1 or 0
            end
            ALU_SLTU: begin
                result = {{(xlen-1){1'b0}}, lt_u};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_PASSB: begin
                result = b;   // lui, imm already shifted by decode
            end
            default: begin
                result = '0;   // unused codes give zero
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/branch_cond.sv */
/*
 * branch condition unit
 * compares rs1 and rs2 under the branch type, signed and unsigned
 */
`timescale 1ns/1ps
`default_nettype none

module branch_cond
    import ex_pkg::*;
#(
    parameter int xlen = 64
) (
    input  br_type_e          br_type,   // comparison select
    input  logic [xlen-1:0]   rs1,
    input  logic [xlen-1:0]   rs2,
    output logic              taken      // condition holds
);

    logic eq;     // equal
    logic lt_s;   // rs1 < rs2 signed
    logic lt_u;   // rs1 < rs2 unsigned

    assign eq   = rs1 == rs2;
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    // is_branch gating lives in the top level
    always_comb begin
        case (br_type)
            BR_EQ:   taken = eq;
            BR_NE:   taken = !eq;
            BR_LT:   taken = lt_s;
            BR_GE:   taken = !lt_s;
            BR_LTU:  taken = lt_u;
            BR_GEU:  taken = !lt_u;
            default: taken = 1'b0;   // reserved funct3 codes
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pipe_ex_stage.sv */
/*
 * execute stage of the five-stage pipeline
 * operand select, alu, branch and jump resolution, ex/mem register
 * a high stall level freezes every output register
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_ex_stage
    import ex_pkg::*;
#(
    parameter int xlen = 64
) (
    input  logic              clk,
    input  logic              reset,          // async, active low
    input  logic              stall,          // hold all ex/mem state

    input  logic [xlen-1:0]   rs1_data,       // from decode
    input  logic [xlen-1:0]   rs2_data,
    input  logic [xlen-1:0]   imm,
    input  logic [xlen-1:0]   pc,
    input  logic [4:0]        rd,             // destination register
    input  logic              rf_wr_en,       // write-back enable
    input  logic [1:0]        rf_wr_sel,      // write-back source select
    input  alu_op_e           alu_op,
    input  logic              a_sel,          // 0 pc, 1 rs1
    input  logic              b_sel,          // 0 rs2, 1 imm
    input  logic [2:0]        mem_rd_ctrl,    // load type, 0 idle
    input  logic [2:0]        mem_wr_ctrl,    // store type, 0 idle
    input  logic              do_jump,        // jal / jalr
    input  logic              is_branch,      // conditional branch
    input  br_type_e          br_type,

    output logic [xlen-1:0]   pc_ex,
    output logic [xlen-1:0]   alu_result_ex,
    output logic              branch_taken_ex,
    output logic [xlen-1:0]   branch_target_ex,
    output logic [xlen-1:0]   store_data_ex,  // rs2 on to memory stage
    output logic [4:0]        rd_ex,
    output logic              rf_wr_en_ex,
    output logic [1:0]        rf_wr_sel_ex,
    output logic [2:0]        mem_rd_ctrl_ex,
    output logic [2:0]        mem_wr_ctrl_ex
);

    logic [xlen-1:0] op_a;         // alu operand a
    logic [xlen-1:0] op_b;         // alu operand b
    logic [xlen-1:0] alu_result;
    logic            br_cond;      // compare result, not yet qualified
    logic            redirect;     // pc must change
    logic [xlen-1:0] target;       // pc relative target

    // operand muxes
    assign op_a = a_sel ? rs1_data : pc;
    assign op_b = b_sel ? imm : rs2_data;

    alu #(
        .xlen   (xlen)
    ) u_alu (
        .op     (alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // always compares the register operands
    branch_cond #(
        .xlen    (xlen)
    ) u_branch_cond (
        .br_type (br_type),
        .rs1     (rs1_data),
        .rs2     (rs2_data),
        .taken   (br_cond)
    );

    assign redirect = do_jump | (is_branch & br_cond);   // jumps always taken
    assign target   = pc + imm;

    // redirect outputs, target forced to zero when not taken
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            branch_taken_ex  <= 1'b0;
            branch_target_ex <= '0;
        end else if (!stall) begin
            branch_taken_ex  <= redirect;
            branch_target_ex <= redirect ? target : '0;
        end
    end

    // result and pass-through fields toward mem and wb
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_ex          <= '0;
            alu_result_ex  <= '0;
            store_data_ex  <= '0;
            rd_ex          <= '0;
            rf_wr_en_ex    <= 1'b0;   // idle, no write-back
            rf_wr_sel_ex   <= '0;
            mem_rd_ctrl_ex <= '0;     // idle, no load
            mem_wr_ctrl_ex <= '0;     // idle, no store
        end else if (!stall) begin
            pc_ex          <= pc;
            alu_result_ex  <= alu_result;
            store_data_ex  <= rs2_data;
            rd_ex          <= rd;
            rf_wr_en_ex    <= rf_wr_en;
            rf_wr_sel_ex   <= rf_wr_sel;
            mem_rd_ctrl_ex <= mem_rd_ctrl;
            mem_wr_ctrl_ex <= mem_wr_ctrl;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
 * clock and reset source for the execute stage testbench
 * 4 ns clock, active-low reset held for three cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset     // active low
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        reset = 1'b0;             // asserted from time zero
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;             // release between rising edges
    end

endmodule

`default_nettype wire

/* testbench/tb_pipe_ex_stage.sv */
/*
 * testbench for the execute stage
 * replays vectors from the stimulus file and checks the ex/mem register
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ex_stage
    import ex_pkg::*;
();

    localparam int xlen     = 64;
    localparam int max_vec  = 64;
    localparam int n_fields = 20;

    // column positions in a vector line
    localparam int f_stall = 0, f_rs1 = 1, f_rs2 = 2, f_imm = 3, f_pc = 4;
    localparam int f_op = 5, f_asel = 6, f_bsel = 7, f_isbr = 8, f_jump = 9;
    localparam int f_brt = 10, f_rd = 11, f_wen = 12, f_wsel = 13, f_mrd = 14;
    localparam int f_mwr = 15, f_exp_alu = 16, f_exp_taken = 17;
    localparam int f_exp_target = 18, f_exp_rd = 19;

    logic            clk;
    logic            reset;
    logic            stall;
    logic [xlen-1:0] rs1_data, rs2_data, imm, pc;
    logic [4:0]      rd;
    logic            rf_wr_en;
    logic [1:0]      rf_wr_sel;
    alu_op_e         alu_op;
    logic            a_sel, b_sel;
    logic [2:0]      mem_rd_ctrl, mem_wr_ctrl;
    logic            do_jump, is_branch;
    br_type_e        br_type;

    logic [xlen-1:0] pc_ex, alu_result_ex, branch_target_ex, store_data_ex;
    logic            branch_taken_ex;
    logic [4:0]      rd_ex;
    logic            rf_wr_en_ex;
    logic [1:0]      rf_wr_sel_ex;
    logic [2:0]      mem_rd_ctrl_ex, mem_wr_ctrl_ex;

    logic [63:0] vec [0:max_vec-1][0:n_fields-1];   // loaded vectors
    int          n_vec;
    int          cycles;     // timeout counter
    int          limit;      // vector count plus margin
    integer      seed;       // for don't-care operands

    tb_clock_gen clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    pipe_ex_stage #(
        .xlen (xlen)
    ) DUT (
        .clk (clk), .reset (reset), .stall (stall),
        .rs1_data (rs1_data), .rs2_data (rs2_data), .imm (imm), .pc (pc),
        .rd (rd), .rf_wr_en (rf_wr_en), .rf_wr_sel (rf_wr_sel),
        .alu_op (alu_op), .a_sel (a_sel), .b_sel (b_sel),
        .mem_rd_ctrl (mem_rd_ctrl), .mem_wr_ctrl (mem_wr_ctrl),
        .do_jump (do_jump), .is_branch (is_branch), .br_type (br_type),
        .pc_ex (pc_ex), .alu_result_ex (alu_result_ex),
        .branch_taken_ex (branch_taken_ex), .branch_target_ex (branch_target_ex),
        .store_data_ex (store_data_ex), .rd_ex (rd_ex), .rf_wr_en_ex (rf_wr_en_ex),
        .rf_wr_sel_ex (rf_wr_sel_ex), .mem_rd_ctrl_ex (mem_rd_ctrl_ex),
        .mem_wr_ctrl_ex (mem_wr_ctrl_ex)
    );

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          count;
        string       line;
        logic [63:0] f [0:n_fields-1];
        fd = $fopen("testbench/ex_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/ex_stimulus.txt");
            fail_run();
        end else begin
            n_vec = 0;
            while (!$feof(fd) && n_vec < max_vec) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin   // skip column notes
                    count = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                        f[18], f[19]);
                    if (count == n_fields) begin   // blank lines fall out here
                        for (int k = 0; k < n_fields; k++) vec[n_vec][k] = f[k];
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            if (n_vec == 0) begin
                $display("the stimulus file holds no complete vector");
                fail_run();
            end
        end
    endtask

    task automatic drive_vector(input int i);
        logic hold;
        hold = vec[i][f_stall][0];
        stall <= hold;
        if (hold) begin   // operands are don't care while frozen
            rs1_data <= {$random(seed), $random(seed)};
            rs2_data <= {$random(seed), $random(seed)};
            imm      <= {$random(seed), $random(seed)};
            pc       <= {$random(seed), $random(seed)};
        end else begin
            rs1_data <= vec[i][f_rs1];
            rs2_data <= vec[i][f_rs2];
            imm      <= vec[i][f_imm];
            pc       <= vec[i][f_pc];
        end
        alu_op      <= alu_op_e'(vec[i][f_op][3:0]);
        a_sel       <= vec[i][f_asel][0];
        b_sel       <= vec[i][f_bsel][0];
        is_branch   <= vec[i][f_isbr][0];
        do_jump     <= vec[i][f_jump][0];
        br_type     <= br_type_e'(vec[i][f_brt][2:0]);
        rd          <= vec[i][f_rd][4:0];
        rf_wr_en    <= vec[i][f_wen][0];
        rf_wr_sel   <= vec[i][f_wsel][1:0];
        mem_rd_ctrl <= vec[i][f_mrd][2:0];
        mem_wr_ctrl <= vec[i][f_mwr][2:0];
    endtask

    // results from the file and pass-through fields from the last unstalled vector
    task automatic check_outputs(input int i, input int live);
        check_value("alu_result_ex", alu_result_ex, vec[i][f_exp_alu]);
        check_value("branch_taken_ex", 64'(branch_taken_ex), vec[i][f_exp_taken]);
        check_value("branch_target_ex", branch_target_ex, vec[i][f_exp_target]);
        check_value("rd_ex", 64'(rd_ex), vec[i][f_exp_rd]);
        check_value("pc_ex", pc_ex, vec[live][f_pc]);
        check_value("store_data_ex", store_data_ex, vec[live][f_rs2]);
        check_value("rf_wr_en_ex", 64'(rf_wr_en_ex), vec[live][f_wen]);
        check_value("rf_wr_sel_ex", 64'(rf_wr_sel_ex), vec[live][f_wsel]);
        check_value("mem_rd_ctrl_ex", 64'(mem_rd_ctrl_ex), vec[live][f_mrd]);
        check_value("mem_wr_ctrl_ex", 64'(mem_wr_ctrl_ex), vec[live][f_mwr]);
    endtask

    // run limit counted from time zero
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: vectors not finished after %0d cycles", limit);
            fail_run();
        end
    end

    initial begin
        int live;
        live = 0;
        seed = 23129;
        stall = 1'b0;
        rs1_data = {$random(seed), $random(seed)};   // noise under reset
        rs2_data = {$random(seed), $random(seed)};
        imm = {$random(seed), $random(seed)};
        pc = {$random(seed), $random(seed)};
        rd = 5'h1f;                                  // busy controls under reset
        rf_wr_en = 1'b1;
        rf_wr_sel = 2'b11;
        alu_op = ALU_ADD;
        a_sel = 1'b0;
        b_sel = 1'b0;
        mem_rd_ctrl = 3'b111;
        mem_wr_ctrl = 3'b111;
        do_jump = 1'b1;
        is_branch = 1'b0;
        br_type = BR_EQ;
        load_vectors();
        limit = n_vec + 20;
        @(posedge reset);
        check_value("pc_ex", pc_ex, '0);   // idle state out of reset
        check_value("alu_result_ex", alu_result_ex, '0);
        check_value("branch_taken_ex", 64'(branch_taken_ex), '0);
        check_value("branch_target_ex", branch_target_ex, '0);
        check_value("store_data_ex", store_data_ex, '0);
        check_value("rd_ex", 64'(rd_ex), '0);
        check_value("rf_wr_en_ex", 64'(rf_wr_en_ex), '0);
        check_value("rf_wr_sel_ex", 64'(rf_wr_sel_ex), '0);
        check_value("mem_rd_ctrl_ex", 64'(mem_rd_ctrl_ex), '0);
        check_value("mem_wr_ctrl_ex", 64'(mem_wr_ctrl_ex), '0);
        for (int i = 0; i <= n_vec; i++) begin
            @(posedge clk);
            if (i < n_vec) drive_vector(i);   // vector i-1 captured on this edge
            if (i > 0) begin
                @(negedge clk);
                if (!vec[i-1][f_stall][0]) live = i - 1;
                check_outputs(i - 1, live);
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ex_stimulus.txt */
# stall rs1 rs2 imm pc alu_op a_sel b_sel is_branch do_jump br_type rd rf_wr_en rf_wr_sel
# mem_rd mem_wr, then expected alu_result branch_taken branch_target rd; all hex
0 3000 deadbeef 8 1000 0 1 1 0 0 0 0 0 0 0 3 3008 0 0 0
0 3 5 0 1004 1 1 0 0 0 0 2 1 0 0 0 fffffffffffffffe 0 0 2
0 1 43 0 1008 2 1 0 0 0 0 3 1 0 0 0 8 0 0 3
0 ffffffffffffffff 1 0 100c 3 1 0 0 0 0 4 1 0 0 0 1 0 0 4
0 ffffffffffffffff 1 0 1010 4 1 0 0 0 0 5 1 0 0 0 0 0 0 5
0 f0f0 ff00 0 1014 5 1 0 0 0 0 6 1 0 0 0 ff0 0 0 6
0 8000000000000000 4 0 1018 6 1 0 0 0 0 7 1 0 0 0 0800000000000000 0 0 7
0 8000000000000000 4 0 101c 7 1 0 0 0 0 8 1 0 0 0 f800000000000000 0 0 8
0 f0 f 0 1020 8 1 0 0 0 0 9 1 0 0 0 ff 0 0 9
0 f0f 55 ff 1024 9 1 1 0 0 0 a 1 1 5 0 f 0 0 a
0 0 0 12345000 1028 a 1 1 0 0 0 b 1 0 0 0 12345000 0 0 b
0 0 0 100 2000 0 0 1 0 0 0 c 1 0 0 0 2100 0 0 c
0 7 7 100 5000 0 0 1 0 1 1 1 1 2 0 0 5100 1 5100 1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5100 1 5100 1
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5100 1 5100 1
0 9 9 20 4000 0 1 0 1 0 0 0 0 0 0 0 12 1 4020 0
0 9 8 20 4004 0 1 0 1 0 0 0 0 0 0 0 11 0 0 0
0 1 2 fffffffffffffff8 4008 0 1 0 1 0 1 0 0 0 0 0 3 1 4000 0
0 2 2 8 400c 0 1 0 1 0 1 0 0 0 0 0 4 0 0 0
0 ffffffffffffffff 1 10 4010 0 1 0 1 0 4 0 0 0 0 0 0 1 4020 0
0 1 ffffffffffffffff 10 4014 0 1 0 1 0 4 0 0 0 0 0 0 0 0 0
0 1 ffffffffffffffff 40 4018 0 1 0 1 0 5 0 0 0 0 0 0 1 4058 0
0 ffffffffffffffff 1 40 401c 0 1 0 1 0 5 0 0 0 0 0 0 0 0 0
0 1 ffffffffffffffff 4 4020 0 1 0 1 0 6 0 0 0 0 0 0 1 4024 0
0 ffffffffffffffff 1 4 4024 0 1 0 1 0 6 0 0 0 0 0 0 0 0 0
0 ffffffffffffffff 1 8 4028 0 1 0 1 0 7 0 0 0 0 0 0 1 4030 0
0 1 ffffffffffffffff 8 402c 0 1 0 1 0 7 0 0 0 0 0 0 0 0 0

/* build.f */
verilog/ex_pkg.sv
verilog/alu.sv
verilog/branch_cond.sv
verilog/pipe_ex_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_pipe_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

top=tb_pipe_ex_stage
obj_dir=obj_dir
compile_log=compile.log
sim_log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 --top-module "$top" -Mdir "$obj_dir" \
    -f build.f > "$compile_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$compile_log"
    echo "compile failed with status $status"
    exit 1
fi

"./$obj_dir/V$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^Simulation completed successfully$" "$sim_log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
